//--- all.f
+incdir+src
src/hk_spi_pkg.sv
src/spi_frame_decoder.sv
src/hk_register_file.sv
src/spi_read_shifter.sv
src/housekeeping_spi_top.sv
testbench/hk_spi_chk.sv
testbench/hk_spi_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= hk_spi_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := TESTBENCH FAILED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	test $$rc -eq 0 && ! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/hk_spi_tb.sv
// Housekeeping SPI testbench with clock, reset, SPI byte tasks, shadow model and directed tests
`default_nettype none

`include "hk_spi_settings.svh"

module hk_spi_tb;

    localparam int num_gp     = `HK_SPI_NUM_GP_REGS;
    localparam int first_gp   = `HK_SPI_FIRST_GP_ADDR;
    localparam int max_cycles = 3000;

    logic SCK;
    logic csb_reset;
    logic csb;
    logic sdi;
    logic sdo;
    logic sdoenb;
    logic pass_thru_mgmt;
    logic pass_thru_user;
    logic pass_thru_mgmt_reset;
    logic pass_thru_user_reset;

    logic [7:0] shadow [num_gp];
    logic       enb_low;
    logic       enb_high;
    int         errors;
    int         checks;
    int         cycles;

    housekeeping_spi_top u_dut (
        .SCK                  (SCK),
        .csb_reset            (csb_reset),
        .csb                  (csb),
        .sdi                  (sdi),
        .sdo                  (sdo),
        .sdoenb               (sdoenb),
        .pass_thru_mgmt       (pass_thru_mgmt),
        .pass_thru_user       (pass_thru_user),
        .pass_thru_mgmt_reset (pass_thru_mgmt_reset),
        .pass_thru_user_reset (pass_thru_user_reset)
    );

    bind housekeeping_spi_top hk_spi_chk u_chk (
        .SCK                  (SCK),
        .csb_reset            (csb_reset),
        .csb                  (csb),
        .frame_reset          (frame_reset),
        .sdoenb               (sdoenb),
        .wr_write             (wr_req.write),
        .pass_thru_mgmt       (pass_thru_mgmt),
        .pass_thru_user       (pass_thru_user),
        .pass_thru_mgmt_reset (pass_thru_mgmt_reset),
        .pass_thru_user_reset (pass_thru_user_reset),
        .state                (u_decoder.state)
    );

    always #5 SCK = ~SCK;

    // Run limit of roughly four times the bit cycles of all tests
    always @(posedge SCK) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Checking and reference model
    // ------------------------------

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error %s: expected %02h, actual %02h", name, expected, actual);
        end
    endtask

    // Read value of an address from the map rules
    function automatic logic [7:0] expected_byte(input int a);
        logic [31:0] mask;
        mask = `HK_SPI_MASK_ID;
        if (a == 1) return `HK_SPI_MFG_ID_LO;
        if (a == 2) return {4'h0, `HK_SPI_MFG_ID_HI};
        if (a == 3) return `HK_SPI_PRODUCT_ID;
        // Mask ID msb at address 4
        if (a >= 4 && a <= 7) return mask[8*(7-a) +: 8];
        if (a >= first_gp && a < first_gp + num_gp) return shadow[a - first_gp];
        return 8'h00;
    endfunction

    // ------------------------------
    // SPI master
    // ------------------------------

    // Called and left at a falling edge
    task automatic start_frame();
        @(negedge SCK);
        csb = 1'b0;
    endtask

    // One extra rising edge lets the last write land before csb rises
    task automatic end_frame();
        @(posedge SCK);
        @(negedge SCK);
        csb = 1'b1;
        sdi = 1'b0;
        @(negedge SCK);
    endtask

    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            sdi = tx[i];
            @(posedge SCK);
            rx[i] = sdo;
            if (sdoenb == 1'b0) begin
                enb_low = 1'b1;
            end else begin
                enb_high = 1'b1;
            end
            @(negedge SCK);
        end
    endtask

    // Shadow takes the random data only inside the writable range
    task automatic write_burst(input logic [7:0] cmd, input int addr, input int count);
        logic [7:0] rx;
        logic [7:0] data;
        start_frame();
        spi_byte(cmd, rx);
        spi_byte(8'(addr), rx);
        for (int i = 0; i < count; i++) begin
            data = 8'($urandom);
            spi_byte(data, rx);
            if (addr + i >= first_gp && addr + i < first_gp + num_gp) begin
                shadow[addr + i - first_gp] = data;
            end
        end
        end_frame();
    endtask

    task automatic read_burst(input string name, input logic [7:0] cmd, input int addr,
                              input int count);
        logic [7:0] rx;
        start_frame();
        spi_byte(cmd, rx);
        spi_byte(8'(addr), rx);
        for (int i = 0; i < count; i++) begin
            enb_high = 1'b0;
            spi_byte(8'h00, rx);
            check_value(name, expected_byte(addr + i), rx);
            // Enable stays low for every bit of a read byte
            check_value({name, " sdoenb"}, 8'd0, 8'(enb_high));
        end
        end_frame();
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic test_id_read();
        logic [7:0] rx;
        start_frame();
        spi_byte(8'h78, rx);
        spi_byte(8'h01, rx);
        for (int i = 0; i < 7; i++) begin
            enb_high = 1'b0;
            spi_byte(8'h00, rx);
            check_value("test_id_read", expected_byte(1 + i), rx);
            check_value("test_id_read sdoenb low", 8'd0, 8'(enb_high));
        end
        // Count is exhausted so this byte is a command
        enb_low = 1'b0;
        spi_byte(8'h00, rx);
        check_value("test_id_read sdoenb", 8'd0, 8'(enb_low));
        end_frame();
    endtask

    task automatic test_write_readback();
        write_burst(8'h80, first_gp, 8);
        read_burst("test_write_readback", 8'h40, first_gp, 8);
    endtask

    task automatic test_byte_count();
        logic [7:0] rx;
        logic [7:0] d0;
        logic [7:0] d1;
        d0 = 8'($urandom);
        d1 = 8'($urandom);
        start_frame();
        spi_byte(8'h88, rx);
        spi_byte(8'(first_gp + 8), rx);
        spi_byte(d0, rx);
        spi_byte(8'h88, rx);
        spi_byte(8'(first_gp + 9), rx);
        spi_byte(d1, rx);
        end_frame();
        shadow[8] = d0;
        shadow[9] = d1;
        read_burst("test_byte_count", 8'h50, first_gp + 8, 2);
    endtask

    task automatic test_protected();
        write_burst(8'h80, 0, 8);
        write_burst(8'h80, first_gp + num_gp, 2);
        read_burst("test_protected", 8'h40, 0, first_gp + 2);
        read_burst("test_protected", 8'h40, first_gp + num_gp - 2, 4);
    endtask

    // Each byte returns the old value while the new one is stored
    task automatic test_read_write();
        logic [7:0] rx;
        logic [7:0] data;
        start_frame();
        spi_byte(8'hC0, rx);
        spi_byte(8'(first_gp), rx);
        for (int i = 0; i < 4; i++) begin
            data = 8'($urandom);
            spi_byte(data, rx);
            check_value("test_read_write old", shadow[i], rx);
            shadow[i] = data;
        end
        end_frame();
        read_burst("test_read_write new", 8'h40, first_gp, 4);
    endtask

    task automatic pass_frame(input logic [7:0] cmd, input logic mgmt);
        logic [7:0] rx;
        start_frame();
        enb_low = 1'b0;
        spi_byte(cmd, rx);
        spi_byte(8'h00, rx);
        check_value("test_pass_thru mgmt", 8'(mgmt), 8'(pass_thru_mgmt));
        check_value("test_pass_thru mgmt_reset", 8'(mgmt), 8'(pass_thru_mgmt_reset));
        check_value("test_pass_thru user", 8'(!mgmt), 8'(pass_thru_user));
        check_value("test_pass_thru user_reset", 8'(!mgmt), 8'(pass_thru_user_reset));
        check_value("test_pass_thru sdoenb", 8'd0, 8'(enb_low));
        end_frame();
        check_value("test_pass_thru idle", 8'd0, 8'({pass_thru_mgmt, pass_thru_user,
                    pass_thru_mgmt_reset, pass_thru_user_reset}));
    endtask

    task automatic test_pass_thru();
        pass_frame(8'hC4, 1'b1);
        pass_frame(8'hC2, 1'b0);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        int unsigned seed;
        seed      = 32'h9094_4580;
        SCK       = 1'b0;
        csb_reset = 1'b1;
        csb       = 1'b1;
        sdi       = 1'b0;
        enb_low   = 1'b0;
        enb_high  = 1'b0;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        void'($urandom(seed));
        // Registers clear on power-on reset
        for (int i = 0; i < num_gp; i++) begin
            shadow[i] = 8'h00;
        end
        repeat (4) @(posedge SCK);
        @(negedge SCK);
        csb_reset = 1'b0;

        test_id_read();
        test_write_readback();
        test_byte_count();
        test_protected();
        test_read_write();
        test_pass_thru();

        $display("Errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/hk_spi_chk.sv
// Bound checker for the housekeeping SPI top level: sdo enable, write strobe, pass flags, frame start
`default_nettype none

module hk_spi_chk (
    input wire                           SCK,
    input wire                           csb_reset,
    input wire                           csb,
    input wire                           frame_reset,
    input wire                           sdoenb,
    input wire                           wr_write,
    input wire                           pass_thru_mgmt,
    input wire                           pass_thru_user,
    input wire                           pass_thru_mgmt_reset,
    input wire                           pass_thru_user_reset,
    input wire hk_spi_pkg::frame_state_e state
);

    // Rising edges seen since csb fell, saturates at 16
    logic [4:0] edge_cnt;

    always_ff @(posedge SCK or posedge frame_reset) begin
        if (frame_reset) begin
            edge_cnt <= 5'd0;
        end else if (edge_cnt != 5'd16) begin
            edge_cnt <= edge_cnt + 5'd1;
        end
    end

    // ------------------------------
    // Properties
    // ------------------------------

    // No read drive outside a frame
    a_sdoenb_idle: assert property (@(posedge SCK) disable iff (csb_reset) csb |-> sdoenb)
        else $error("sdoenb low while csb is high");

    // Write strobe is a single cycle pulse
    a_write_pulse: assert property (@(posedge SCK) disable iff (frame_reset)
        wr_write |=> !wr_write)
        else $error("wr_req.write held for two cycles");

    a_mgmt_order: assert property (@(posedge SCK) disable iff (csb_reset)
        $rose(pass_thru_mgmt) |-> pass_thru_mgmt_reset)
        else $error("pass_thru_mgmt rose without its reset request");

    a_user_order: assert property (@(posedge SCK) disable iff (csb_reset)
        $rose(pass_thru_user) |-> pass_thru_user_reset)
        else $error("pass_thru_user rose without its reset request");

    // Command and address take the first 16 edges
    a_data_late: assert property (@(posedge SCK) disable iff (frame_reset)
        (edge_cnt < 5'd16) |-> (state != hk_spi_pkg::FRAME_DATA))
        else $error("data state reached within 16 edges of csb falling");

endmodule

`default_nettype wire

//--- src/housekeeping_spi_top.sv
// Top level of the housekeeping SPI slave: decoder, register file and read shifter
`default_nettype none

module housekeeping_spi_top (
    input  wire  SCK,
    input  wire  csb_reset,
    input  wire  csb,
    input  wire  sdi,
    output logic sdo,
    output logic sdoenb,
    output logic pass_thru_mgmt,
    output logic pass_thru_user,
    output logic pass_thru_mgmt_reset,
    output logic pass_thru_user_reset
);

    hk_spi_pkg::reg_req_t   wr_req;
    hk_spi_pkg::shift_ctl_t shift_ctl;
    logic [7:0]             rd_addr;
    logic [7:0]             rd_data;
    logic                   frame_reset;

    // ------------------------------
    // Stage one, rising edge decode
    // ------------------------------

    spi_frame_decoder u_decoder (
        .SCK                  (SCK),
        .csb_reset            (csb_reset),
        .csb                  (csb),
        .sdi                  (sdi),
        .wr_req               (wr_req),
        .rd_addr              (rd_addr),
        .shift_ctl            (shift_ctl),
        .frame_reset          (frame_reset),
        .pass_thru_mgmt       (pass_thru_mgmt),
        .pass_thru_user       (pass_thru_user),
        .pass_thru_mgmt_reset (pass_thru_mgmt_reset),
        .pass_thru_user_reset (pass_thru_user_reset)
    );

    // Stage two, registers survive csb
    hk_register_file u_regs (
        .SCK       (SCK),
        .csb_reset (csb_reset),
        .wr_req    (wr_req),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    // Stage three, falling edge output
    spi_read_shifter u_shifter (
        .SCK         (SCK),
        .frame_reset (frame_reset),
        .shift_ctl   (shift_ctl),
        .rd_data     (rd_data),
        .sdo         (sdo),
        .sdoenb      (sdoenb)
    );

endmodule

`default_nettype wire

//--- src/spi_read_shifter.sv
// Read shifter: falling edge load and shift of read data, sdo and its enable
`default_nettype none

module spi_read_shifter (
    input  wire                       SCK,
    input  wire                       frame_reset,
    input  wire hk_spi_pkg::shift_ctl_t shift_ctl,
    input  wire [7:0]                 rd_data,
    output logic                      sdo,
    output logic                      sdoenb
);

    logic [7:0] ldata;

    // Msb leads, master samples it on the next rising edge
    assign sdo = ldata[7];

    // ------------------------------
    // Falling edge shift register
    // ------------------------------

    always_ff @(negedge SCK or posedge frame_reset) begin
        if (frame_reset) begin
            ldata <= 8'd0;
        end else if (shift_ctl.load) begin
            // Byte boundary, take the word at the new address
            ldata <= rd_data;
        end else if (shift_ctl.shift) begin
            ldata <= {ldata[6:0], 1'b0};
        end
    end

    // Active low enable, released between read bytes and in pass-through
    always_ff @(negedge SCK or posedge frame_reset) begin
        if (frame_reset) begin
            sdoenb <= 1'b1;
        end else begin
            sdoenb <= ~shift_ctl.drive;
        end
    end

endmodule

`default_nettype wire

//--- src/hk_register_file.sv
// Register file: identification constants, general purpose bytes, write and read ports
`default_nettype none

`include "hk_spi_settings.svh"

module hk_register_file (
    input  wire                  SCK,
    input  wire                  csb_reset,
    input  wire hk_spi_pkg::reg_req_t wr_req,
    input  wire [7:0]            rd_addr,
    output logic [7:0]           rd_data
);

    localparam int NUM_GP = `HK_SPI_NUM_GP_REGS;
    localparam int IDX_W  = (NUM_GP > 1) ? $clog2(NUM_GP) : 1;

    localparam logic [7:0]  FIRST_GP   = 8'(`HK_SPI_FIRST_GP_ADDR);
    localparam logic [7:0]  LAST_GP    = 8'(`HK_SPI_FIRST_GP_ADDR + NUM_GP - 1);
    localparam logic [31:0] MASK_ID    = `HK_SPI_MASK_ID;
    localparam logic [7:0]  MFG_ID_LO  = `HK_SPI_MFG_ID_LO;
    localparam logic [3:0]  MFG_ID_HI  = `HK_SPI_MFG_ID_HI;
    localparam logic [7:0]  PRODUCT_ID = `HK_SPI_PRODUCT_ID;

    logic [7:0] gp_regs [NUM_GP];
    logic [7:0] wr_off;
    logic [7:0] rd_off;
    logic       wr_in_range;
    logic       rd_in_range;

    // Offsets into the general purpose block
    assign wr_off      = wr_req.addr - FIRST_GP;
    assign rd_off      = rd_addr - FIRST_GP;
    assign wr_in_range = (wr_req.addr >= FIRST_GP) && (wr_req.addr <= LAST_GP);
    assign rd_in_range = (rd_addr >= FIRST_GP) && (rd_addr <= LAST_GP);

    // ------------------------------
    // Write port
    // ------------------------------

    // Only power-on reset clears the registers, csb leaves them alone
    always_ff @(posedge SCK or posedge csb_reset) begin
        if (csb_reset) begin
            for (int i = 0; i < NUM_GP; i++) begin
                gp_regs[i] <= 8'd0;
            end
        end else if (wr_req.write && wr_in_range) begin
            gp_regs[wr_off[IDX_W-1:0]] <= wr_req.wdata;
        end
    end

    // ------------------------------
    // Read port
    // ------------------------------

    // Combinational, a same-cycle write is not yet visible
    always_comb begin
        case (rd_addr)
            8'd1: rd_data = MFG_ID_LO;
            8'd2: rd_data = {4'h0, MFG_ID_HI};
            8'd3: rd_data = PRODUCT_ID;
            // Mask ID msb first
            8'd4: rd_data = MASK_ID[31:24];
            8'd5: rd_data = MASK_ID[23:16];
            8'd6: rd_data = MASK_ID[15:8];
            8'd7: rd_data = MASK_ID[7:0];
            default: begin
                if (rd_in_range) begin
                    rd_data = gp_regs[rd_off[IDX_W-1:0]];
                end else begin
                    // Address 0 and anything past the block
                    rd_data = 8'd0;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/spi_frame_decoder.sv
// Frame decoder: bit counter, frame FSM, command capture, address counter, write requests
`default_nettype none

module spi_frame_decoder (
    input  wire                   SCK,
    input  wire                   csb_reset,
    input  wire                   csb,
    input  wire                   sdi,
    output hk_spi_pkg::reg_req_t  wr_req,
    output logic [7:0]            rd_addr,
    output hk_spi_pkg::shift_ctl_t shift_ctl,
    output logic                  frame_reset,
    output logic                  pass_thru_mgmt,
    output logic                  pass_thru_user,
    output logic                  pass_thru_mgmt_reset,
    output logic                  pass_thru_user_reset
);

    hk_spi_pkg::frame_state_e state;
    hk_spi_pkg::frame_state_e next_state;

    logic [2:0] bit_cnt;
    logic [6:0] cmd_sr;
    logic       cmd_write;
    logic       cmd_read;
    logic [2:0] byte_cnt;
    logic [7:0] addr;
    logic [6:0] data_sr;
    logic       wr_valid;
    logic [7:0] wr_addr;
    logic [7:0] wr_wdata;
    logic       byte_done;
    logic       last_byte;
    logic       addr_done;
    logic       load_next;
    logic       drive_next;

    // Frame logic is cleared by power-on reset or by csb high
    assign frame_reset = csb_reset | csb;

    // Eighth bit of the current byte is on sdi
    assign byte_done = (bit_cnt == 3'd7);
    // Unlimited transfers keep byte_cnt at zero and never hit this
    assign last_byte = (byte_cnt == 3'd1);
    assign addr_done = (state == hk_spi_pkg::FRAME_ADDRESS) && byte_done;

    assign rd_addr = addr;
    assign wr_req  = '{write: wr_valid, addr: wr_addr, wdata: wr_wdata};

    // ------------------------------
    // Frame FSM
    // ------------------------------

    always_comb begin
        next_state = state;
        case (state)
            hk_spi_pkg::FRAME_COMMAND: begin
                if (byte_done) begin
                    // cmd_sr[1] is bit 2 (mgmt), cmd_sr[0] is bit 1 (user)
                    if (cmd_sr[1] && !cmd_sr[0]) begin
                        next_state = hk_spi_pkg::FRAME_MGMT_PASS;
                    end else if (cmd_sr[0] && !cmd_sr[1]) begin
                        next_state = hk_spi_pkg::FRAME_USER_PASS;
                    end else begin
                        next_state = hk_spi_pkg::FRAME_ADDRESS;
                    end
                end
            end
            hk_spi_pkg::FRAME_ADDRESS: begin
                if (byte_done) begin
                    next_state = hk_spi_pkg::FRAME_DATA;
                end
            end
            hk_spi_pkg::FRAME_DATA: begin
                // Counted transfer done, next byte is a fresh command
                if (byte_done && last_byte) begin
                    next_state = hk_spi_pkg::FRAME_COMMAND;
                end
            end
            hk_spi_pkg::FRAME_MGMT_PASS,
            hk_spi_pkg::FRAME_USER_PASS: begin
                next_state = state;
            end
            default: begin
                next_state = hk_spi_pkg::FRAME_COMMAND;
            end
        endcase
    end

    always_ff @(posedge SCK or posedge frame_reset) begin
        if (frame_reset) begin
            state   <= hk_spi_pkg::FRAME_COMMAND;
            bit_cnt <= 3'd0;
        end else begin
            state <= next_state;
            // Counter freezes once the frame is handed to a flash
            if (state != hk_spi_pkg::FRAME_MGMT_PASS &&
                state != hk_spi_pkg::FRAME_USER_PASS) begin
                bit_cnt <= bit_cnt + 3'd1;
            end
        end
    end

    // ------------------------------
    // Command capture
    // ------------------------------

    always_ff @(posedge SCK or posedge frame_reset) begin
        if (frame_reset) begin
            cmd_sr               <= 7'd0;
            cmd_write            <= 1'b0;
            cmd_read             <= 1'b0;
            byte_cnt             <= 3'd0;
            pass_thru_mgmt_reset <= 1'b0;
            pass_thru_user_reset <= 1'b0;
        end else if (state == hk_spi_pkg::FRAME_COMMAND) begin
            cmd_sr <= {cmd_sr[5:0], sdi};
            case (bit_cnt)
                // Pass bits raise their reset request as soon as sampled
                3'd5: pass_thru_mgmt_reset <= sdi;
                3'd6: pass_thru_user_reset <= sdi;
                3'd7: begin
                    cmd_write <= cmd_sr[6];
                    cmd_read  <= cmd_sr[5];
                    byte_cnt  <= cmd_sr[4:2];
                    // Both pass bits set is not a pass command, drop the requests
                    pass_thru_mgmt_reset <= (next_state == hk_spi_pkg::FRAME_MGMT_PASS);
                    pass_thru_user_reset <= (next_state == hk_spi_pkg::FRAME_USER_PASS);
                end
                default: begin
                    cmd_write <= cmd_write;
                end
            endcase
        end else if (state == hk_spi_pkg::FRAME_DATA && byte_done && byte_cnt != 3'd0) begin
            byte_cnt <= byte_cnt - 3'd1;
        end
    end

    // Flags follow one edge after entering the pass state
    always_ff @(posedge SCK or posedge frame_reset) begin
        if (frame_reset) begin
            pass_thru_mgmt <= 1'b0;
            pass_thru_user <= 1'b0;
        end else begin
            if (state == hk_spi_pkg::FRAME_MGMT_PASS) begin
                pass_thru_mgmt <= 1'b1;
            end
            if (state == hk_spi_pkg::FRAME_USER_PASS) begin
                pass_thru_user <= 1'b1;
            end
        end
    end

    // ------------------------------
    // Address and write data
    // ------------------------------

    always_ff @(posedge SCK or posedge frame_reset) begin
        if (frame_reset) begin
            addr     <= 8'd0;
            data_sr  <= 7'd0;
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= 1'b0;
            if (state == hk_spi_pkg::FRAME_ADDRESS) begin
                addr <= {addr[6:0], sdi};
            end else if (state == hk_spi_pkg::FRAME_DATA) begin
                data_sr <= {data_sr[5:0], sdi};
                if (byte_done) begin
                    wr_valid <= cmd_write;
                    addr     <= addr + 8'd1;
                end
            end
        end
    end

    // Request payload, qualified by wr_valid
    always_ff @(posedge SCK) begin
        if (state == hk_spi_pkg::FRAME_DATA && byte_done) begin
            wr_addr  <= addr;
            wr_wdata <= {data_sr, sdi};
        end
    end

    // ------------------------------
    // Read shifter control
    // ------------------------------

    // Drive while a read byte is on sdo, load at each byte boundary that continues
    assign drive_next = cmd_read && (addr_done ||
                        (state == hk_spi_pkg::FRAME_DATA && !(byte_done && last_byte)));
    assign load_next  = cmd_read && (addr_done ||
                        (state == hk_spi_pkg::FRAME_DATA && byte_done && !last_byte));

    always_ff @(posedge SCK or posedge frame_reset) begin
        if (frame_reset) begin
            shift_ctl <= '0;
        end else begin
            shift_ctl <= '{load: load_next, shift: drive_next && !load_next, drive: drive_next};
        end
    end

endmodule

`default_nettype wire

//--- src/hk_spi_pkg.sv
// Frame state encoding, register write request and read shifter control types
`default_nettype none

package hk_spi_pkg;

    // ------------------------------
    // Frame state
    // ------------------------------

    // Position of the decoder inside a csb frame
    // Pass states hold until csb rises
    typedef enum logic [2:0] {
        FRAME_COMMAND   = 3'b000,
        FRAME_ADDRESS   = 3'b001,
        FRAME_DATA      = 3'b010,
        FRAME_USER_PASS = 3'b100,
        FRAME_MGMT_PASS = 3'b101
    } frame_state_e;

    // ------------------------------
    // Decoder to register file
    // ------------------------------

    // Registered write request, valid for one SCK cycle
    typedef struct packed {
        logic       write;
        logic [7:0] addr;
        logic [7:0] wdata;
    } reg_req_t;

    // ------------------------------
    // Decoder to read shifter
    // ------------------------------

    // Action for the coming falling edge
    // Load takes precedence over shift in the shifter
    typedef struct packed {
        logic load;
        logic shift;
        logic drive;
    } shift_ctl_t;

endpackage

`default_nettype wire

//--- src/hk_spi_settings.svh
// Identification values and general purpose register range of the housekeeping SPI
`ifndef HK_SPI_SETTINGS_SVH
`define HK_SPI_SETTINGS_SVH

// ------------------------------
// Identification registers
// ------------------------------

// Manufacturer ID low byte, address 1
`define HK_SPI_MFG_ID_LO 8'h56

// Manufacturer ID high nibble, address 2
// Upper nibble of that address reads as zero
`define HK_SPI_MFG_ID_HI 4'h4

// Product ID, address 3
`define HK_SPI_PRODUCT_ID 8'h11

// Mask ID, addresses 4 to 7
// Most significant byte sits at address 4
`define HK_SPI_MASK_ID 32'hA5C3_0F1E

// ------------------------------
// General purpose registers
// ------------------------------

// First writable address, right after the mask ID
`define HK_SPI_FIRST_GP_ADDR 8

// Number of general purpose bytes
// Addresses past the last one read zero
`define HK_SPI_NUM_GP_REGS 16

`endif
